//--- ahci_seq_pkg.sv
`default_nettype none

package ahci_seq_pkg;

    // program word layout
    localparam int PGM_W        = 18;
    localparam int PGM_ADDR_W   = 10;
    localparam int PGM_DEPTH    = 1 << PGM_ADDR_W;   // 1024 words
    localparam int LAST_BIT     = 17;                // last action of a block
    localparam int WAIT_BIT     = 16;                // stall until a done strobe
    localparam int ACT_CODE_W   = 5;                 // action code in low bits
    localparam int COND_SEL_LSB = 10;                // transition word select
    localparam int COND_SEL_W   = 8;
    localparam int TARGET_LSB   = 0;                 // jump target, PGM_ADDR_W wide

    // action pulse vector, bit 0 unused (code 0 = nop)
    localparam int NUM_ACTIONS      = 32;
    localparam int ACT_FETCH_CMD    = 1;
    localparam int ACT_CFIS_XMIT    = 2;
    localparam int ACT_DX_XMIT      = 3;
    localparam int ACT_GET_RFIS     = 4;
    localparam int ACT_GET_DATA_FIS = 5;
    localparam int ACT_PCMD_CR_SET  = 6;
    localparam int ACT_PXCI0_CLEAR  = 7;
    localparam int ACT_SEND_R_OK    = 8;
    localparam int ACT_SEND_R_ERR   = 9;
    localparam int ACT_DMA_ABORT    = 10;
    localparam int ACT_SIRQ_TFE     = 11;

    // conditions, selects at or above NUM_CONDS are false
    localparam int NUM_CONDS            = 16;
    localparam int COND_IDX_W           = $clog2(NUM_CONDS);
    localparam int COND_ALWAYS          = 0;
    localparam int COND_FIS_OK          = 1;
    localparam int COND_FIS_ERR         = 2;
    localparam int COND_FIS_FERR        = 3;
    localparam int COND_FR_D2HR         = 4;
    localparam int COND_FIS_DATA        = 5;
    localparam int COND_FIS_ANY         = 6;
    localparam int COND_NB_ND           = 7;
    localparam int COND_TFD_ERR         = 8;
    localparam int COND_ST_NB_ND        = 9;
    localparam int COND_XFER0           = 10;
    localparam int COND_CHW_DMAA        = 11;
    localparam int COND_CTBA_C          = 12;
    localparam int COND_TX_ERR          = 13;
    localparam int COND_SYNCESC_ERR     = 14;
    localparam int COND_X_RDY_COLLISION = 15;

    localparam logic [7:0] FIS_D2HR = 8'h34;   // D2H register FIS
    localparam logic [7:0] FIS_DATA = 8'h46;   // data FIS

    // fixed entry points
    localparam logic [PGM_ADDR_W-1:0] LABEL_POR        = 10'h000;
    localparam logic [PGM_ADDR_W-1:0] LABEL_HBA_RST    = 10'h002;
    localparam logic [PGM_ADDR_W-1:0] LABEL_PORT_RST   = 10'h004;
    localparam logic [PGM_ADDR_W-1:0] LABEL_COMINIT    = 10'h006;
    localparam logic [PGM_ADDR_W-1:0] LABEL_ST_CLEARED = 10'h008;

endpackage

`default_nettype wire

//--- verilog/fsm_program_ram.sv
`timescale 1ns/10ps
`default_nettype none

module fsm_program_ram (
    input  wire                                  mclk,
    input  wire                                  hba_rst,
    input  wire  [ahci_seq_pkg::PGM_W-1:0]       pgm_ad,   // address or data
    input  wire                                  pgm_wa,   // load write address
    input  wire                                  pgm_wd,   // write word, then advance
    input  wire  [ahci_seq_pkg::PGM_ADDR_W-1:0]  raddr,
    input  wire                                  ren,
    output logic [ahci_seq_pkg::PGM_W-1:0]       rdata     // valid cycle after ren
);
    import ahci_seq_pkg::*;

    logic [PGM_W-1:0]      mem [PGM_DEPTH];
    logic [PGM_ADDR_W-1:0] waddr;                          // program write pointer

    // loading works while the port is held in reset
    always_ff @(posedge mclk) begin
        if (pgm_wa)
            waddr <= pgm_ad[PGM_ADDR_W-1:0];               // new base address
        else if (pgm_wd)
            waddr <= waddr + 1'b1;                         // auto increment
    end

    always_ff @(posedge mclk) begin
        if (pgm_wd)
            mem[waddr] <= pgm_ad;
    end

    always_ff @(posedge mclk) begin
        if (hba_rst)
            rdata <= '0;                                   // nop word during reset
        else if (ren)
            rdata <= mem[raddr];                           // else hold last word
    end

    // address and data strobes share pgm_ad, never together
    a_pgm_strobes: assert property (@(posedge mclk) !(pgm_wa && pgm_wd))
        else $error("pgm_wa and pgm_wd high in the same cycle");

endmodule

`default_nettype wire

//--- verilog/fsm_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module fsm_sequencer (
    input  wire                                  mclk,
    input  wire                                  hba_rst,
    input  wire                                  was_hba_rst,     // picks reset entry
    input  wire                                  was_port_rst,
    input  wire  [ahci_seq_pkg::PGM_W-1:0]       word,            // current program word
    input  wire                                  cond_met,        // selected condition true
    input  wire                                  fis_done,
    input  wire                                  xmit_done,
    input  wire                                  abort_done,
    input  wire                                  cominit_got,
    input  wire                                  unsolicited_en,
    input  wire                                  pcmd_st_cleared,
    output logic [ahci_seq_pkg::PGM_ADDR_W-1:0]  raddr,
    output logic                                 ren,
    output logic                                 act_en,          // fire action of word
    output logic                                 cond_ce,         // take condition snapshot
    output logic [ahci_seq_pkg::PGM_ADDR_W-1:0]  last_jump_addr   // debug
);
    import ahci_seq_pkg::*;

    logic [PGM_ADDR_W-1:0] pgm_addr;          // next address to read
    logic [PGM_ADDR_W-1:0] jump_addr;         // pending jump target
    logic [2:0]            fsm_jump;          // load, preload read, first word valid
    logic                  fsm_preload;
    logic                  fsm_actions;
    logic                  fsm_transitions;
    logic                  fsm_busy;          // waiting for done
    logic                  done_pre;
    logic                  done_r;            // done delayed two cycles
    logic                  async_pend;
    logic                  async_from_st;     // pending request came from ST clear
    logic                  was_rst;

    wire                  last_w    = word[LAST_BIT];
    wire                  wait_w    = word[WAIT_BIT];
    wire [PGM_ADDR_W-1:0] target_w  = word[TARGET_LSB +: PGM_ADDR_W];
    wire                  done_w    = fis_done | xmit_done | abort_done;
    wire                  async_rq  = (cominit_got & unsolicited_en) | pcmd_st_cleared;
    wire                  start_w   = was_rst & ~hba_rst;              // reset just ended
    wire                  actions_w = fsm_actions | fsm_jump[2];       // first word acts at once
    // stalled, between actions or scanning
    wire                  async_ackn = async_pend & (actions_w | fsm_busy | fsm_transitions);
    wire                  act_fire   = actions_w & ~fsm_busy & ~async_pend;
    wire                  scan_w     = fsm_transitions & ~async_pend;
    wire                  fsm_next   = fsm_preload | act_fire | scan_w;
    wire                  pre_jump   = start_w | async_ackn | (scan_w & cond_met);
    // busy without actions phase means the wait belonged to the last action
    wire                  trans_w    = (act_fire & last_w & ~wait_w) |
                                       (fsm_busy & done_r & ~fsm_actions);

    assign raddr   = pgm_addr;
    assign ren     = fsm_next;
    assign act_en  = act_fire;
    assign cond_ce = trans_w;              // snapshot once, held during scan

    always_ff @(posedge mclk) begin
        was_rst <= hba_rst;
    end

    // address path, no reset needed
    always_ff @(posedge mclk) begin
        if (fsm_jump[0])
            pgm_addr <= jump_addr;         // address load
        else if (fsm_next)
            pgm_addr <= pgm_addr + 1'b1;

        if (hba_rst)
            jump_addr <= was_hba_rst  ? LABEL_HBA_RST :
                         was_port_rst ? LABEL_PORT_RST : LABEL_POR;
        else if (async_pend)
            jump_addr <= async_from_st ? LABEL_ST_CLEARED : LABEL_COMINIT;
        else if (scan_w && cond_met)
            jump_addr <= target_w;         // first true transition wins
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            fsm_jump        <= '0;
            fsm_preload     <= 1'b0;
            fsm_actions     <= 1'b0;
            fsm_transitions <= 1'b0;
            fsm_busy        <= 1'b0;
            done_pre        <= 1'b0;
            done_r          <= 1'b0;
            async_pend      <= 1'b0;
            async_from_st   <= 1'b0;
            last_jump_addr  <= '0;
        end else begin
            fsm_jump    <= {fsm_jump[1:0], pre_jump};
            fsm_preload <= fsm_jump[0];    // read target while loading stage 2
            done_pre    <= done_w;
            done_r      <= done_pre;       // lets inputs settle before snapshot

            if (fsm_jump[0])
                last_jump_addr <= jump_addr;

            if (pre_jump)
                fsm_actions <= 1'b0;       // abandon the block
            else if (act_fire && last_w)
                fsm_actions <= 1'b0;
            else if (fsm_jump[2])
                fsm_actions <= 1'b1;

            if (pre_jump)
                fsm_transitions <= 1'b0;
            else if (trans_w)
                fsm_transitions <= 1'b1;

            if (pre_jump)
                fsm_busy <= 1'b0;          // async acceptance ends the wait
            else if (act_fire)
                fsm_busy <= wait_w;
            else if (done_r)
                fsm_busy <= 1'b0;

            async_pend <= (async_rq | async_pend) & ~async_ackn;
            if (pcmd_st_cleared)
                async_from_st <= 1'b1;
            else if (async_rq && !async_pend)
                async_from_st <= 1'b0;     // cominit only
        end
    end

    // word acts either as action or as transition, never both
    a_phase_excl: assert property (@(posedge mclk) disable iff (hba_rst)
        !(actions_w && fsm_transitions))
        else $error("actions and transitions phase active together");

endmodule

`default_nettype wire

//--- verilog/action_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module action_decoder (
    input  wire                                  mclk,
    input  wire                                  hba_rst,
    input  wire                                  act_en,
    input  wire  [ahci_seq_pkg::ACT_CODE_W-1:0]  code,
    output logic [ahci_seq_pkg::NUM_ACTIONS-1:0] act_pulse   // one cycle, one-hot
);
    import ahci_seq_pkg::*;

    logic [NUM_ACTIONS-1:0] onehot_w;

    always_comb begin
        onehot_w = '0;
        if (code != '0)
            onehot_w[code] = 1'b1;     // code 0 is a nop
    end

    always_ff @(posedge mclk) begin
        if (hba_rst)
            act_pulse <= '0;
        else if (act_en)
            act_pulse <= onehot_w;
        else
            act_pulse <= '0;           // single cycle pulse
    end

    // any pulse is one-hot and follows an enabled word
    a_pulse_onehot: assert property (@(posedge mclk) disable iff (hba_rst)
        (act_pulse != '0) |-> ($onehot(act_pulse) && $past(act_en)))
        else $error("act_pulse not one-hot or not requested");

endmodule

`default_nettype wire

//--- verilog/condition_mux.sv
`timescale 1ns/10ps
`default_nettype none

module condition_mux (
    input  wire                                  mclk,
    input  wire                                  cond_ce,        // snapshot strobe
    input  wire  [ahci_seq_pkg::COND_SEL_W-1:0]  sel,
    input  wire                                  fis_ok,
    input  wire                                  fis_err,
    input  wire                                  fis_ferr,
    input  wire                                  fis_first_vld,
    input  wire  [7:0]                           fis_type,
    input  wire  [7:0]                           tfd_sts,        // bsy 7, drq 3, err 0
    input  wire                                  pcmd_st,
    input  wire                                  xfer_cntr_zero,
    input  wire                                  dma_cmd_busy,
    input  wire                                  ch_w,
    input  wire                                  dma_a,
    input  wire                                  ch_c,
    input  wire  [2:0]                           dx_err,
    output logic                                 cond_met
);
    import ahci_seq_pkg::*;

    logic [NUM_CONDS-1:0] cond_w;
    logic [NUM_CONDS-1:0] cond_r;                  // held while scanning

    wire nb_nd = ~tfd_sts[7] & ~tfd_sts[3];        // not busy, no drq

    always_comb begin
        cond_w[COND_ALWAYS]          = 1'b1;
        cond_w[COND_FIS_OK]          = fis_ok;
        cond_w[COND_FIS_ERR]         = fis_err;
        cond_w[COND_FIS_FERR]        = fis_ferr;
        cond_w[COND_FR_D2HR]         = fis_first_vld & (fis_type == FIS_D2HR);
        cond_w[COND_FIS_DATA]        = fis_first_vld & (fis_type == FIS_DATA);
        cond_w[COND_FIS_ANY]         = fis_first_vld;
        cond_w[COND_NB_ND]           = nb_nd;
        cond_w[COND_TFD_ERR]         = tfd_sts[0];
        cond_w[COND_ST_NB_ND]        = pcmd_st & nb_nd;
        cond_w[COND_XFER0]           = xfer_cntr_zero & ~dma_cmd_busy;
        cond_w[COND_CHW_DMAA]        = ch_w & dma_a;
        cond_w[COND_CTBA_C]          = ch_c;
        cond_w[COND_TX_ERR]          = dx_err[1];  // R_ERR
        cond_w[COND_SYNCESC_ERR]     = dx_err[0];
        cond_w[COND_X_RDY_COLLISION] = dx_err[2];
    end

    always_ff @(posedge mclk) begin
        if (cond_ce)
            cond_r <= cond_w;
    end

    // undefined selects never match
    assign cond_met = (sel < NUM_CONDS) ? cond_r[sel[COND_IDX_W-1:0]] : 1'b0;

endmodule

`default_nettype wire

//--- verilog/ahci_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module ahci_fsm (
    input  wire                                  mclk,
    input  wire                                  hba_rst,
    input  wire                                  was_hba_rst,
    input  wire                                  was_port_rst,
    input  wire  [ahci_seq_pkg::PGM_W-1:0]       pgm_ad,
    input  wire                                  pgm_wa,
    input  wire                                  pgm_wd,
    input  wire                                  fis_done,
    input  wire                                  xmit_done,
    input  wire                                  abort_done,
    input  wire                                  cominit_got,
    input  wire                                  unsolicited_en,
    input  wire                                  pcmd_st_cleared,
    input  wire                                  fis_ok,
    input  wire                                  fis_err,
    input  wire                                  fis_ferr,
    input  wire                                  fis_first_vld,
    input  wire  [7:0]                           fis_type,
    input  wire  [7:0]                           tfd_sts,
    input  wire                                  pcmd_st,
    input  wire                                  xfer_cntr_zero,
    input  wire                                  dma_cmd_busy,
    input  wire                                  ch_w,
    input  wire                                  dma_a,
    input  wire                                  ch_c,
    input  wire  [2:0]                           dx_err,
    output logic [ahci_seq_pkg::NUM_ACTIONS-1:0] act_pulse,
    output logic [ahci_seq_pkg::PGM_ADDR_W-1:0]  last_jump_addr
);
    import ahci_seq_pkg::*;

    logic [PGM_W-1:0]      pgm_word;       // word under execution
    logic [PGM_ADDR_W-1:0] pgm_raddr;
    logic                  pgm_ren;
    logic                  act_en;
    logic                  cond_ce;
    logic                  cond_met;

    fsm_program_ram fsm_program_ram_i (
        .mclk    (mclk),
        .hba_rst (hba_rst),
        .pgm_ad  (pgm_ad),
        .pgm_wa  (pgm_wa),
        .pgm_wd  (pgm_wd),
        .raddr   (pgm_raddr),
        .ren     (pgm_ren),
        .rdata   (pgm_word)
    );

    fsm_sequencer fsm_sequencer_i (
        .mclk            (mclk),
        .hba_rst         (hba_rst),
        .was_hba_rst     (was_hba_rst),
        .was_port_rst    (was_port_rst),
        .word            (pgm_word),
        .cond_met        (cond_met),
        .fis_done        (fis_done),
        .xmit_done       (xmit_done),
        .abort_done      (abort_done),
        .cominit_got     (cominit_got),
        .unsolicited_en  (unsolicited_en),
        .pcmd_st_cleared (pcmd_st_cleared),
        .raddr           (pgm_raddr),
        .ren             (pgm_ren),
        .act_en          (act_en),
        .cond_ce         (cond_ce),
        .last_jump_addr  (last_jump_addr)
    );

    action_decoder action_decoder_i (
        .mclk      (mclk),
        .hba_rst   (hba_rst),
        .act_en    (act_en),
        .code      (pgm_word[ACT_CODE_W-1:0]),            // action code field
        .act_pulse (act_pulse)
    );

    condition_mux condition_mux_i (
        .mclk           (mclk),
        .cond_ce        (cond_ce),
        .sel            (pgm_word[COND_SEL_LSB +: COND_SEL_W]),   // transition select
        .fis_ok         (fis_ok),
        .fis_err        (fis_err),
        .fis_ferr       (fis_ferr),
        .fis_first_vld  (fis_first_vld),
        .fis_type       (fis_type),
        .tfd_sts        (tfd_sts),
        .pcmd_st        (pcmd_st),
        .xfer_cntr_zero (xfer_cntr_zero),
        .dma_cmd_busy   (dma_cmd_busy),
        .ch_w           (ch_w),
        .dma_a          (dma_a),
        .ch_c           (ch_c),
        .dx_err         (dx_err),
        .cond_met       (cond_met)
    );

endmodule

`default_nettype wire

//--- sim/tb_ahci_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ahci_fsm;
    import ahci_seq_pkg::*;

    localparam int RUN_BLOCKS  = 24;                 // blocks walked per test
    localparam int MAX_BLK_LEN = 7;                  // 4 actions + 3 transitions
    localparam int NUM_EXTRA   = 6;                  // blocks beyond the labels
    localparam int NUM_BLKS    = 5 + NUM_EXTRA;
    localparam int WDOG_CYCLES = RUN_BLOCKS * MAX_BLK_LEN * 40;

    logic                   mclk;
    logic                   hba_rst;
    logic                   was_hba_rst;
    logic                   was_port_rst;
    logic [PGM_W-1:0]       pgm_ad;
    logic                   pgm_wa;
    logic                   pgm_wd;
    logic                   fis_done;
    logic                   xmit_done;
    logic                   abort_done;
    logic                   cominit_got;
    logic                   unsolicited_en;
    logic                   pcmd_st_cleared;
    logic                   fis_ok;
    logic                   fis_err;
    logic                   fis_ferr;
    logic                   fis_first_vld;
    logic [7:0]             fis_type;
    logic [7:0]             tfd_sts;
    logic                   pcmd_st;
    logic                   xfer_cntr_zero;
    logic                   dma_cmd_busy;
    logic                   ch_w;
    logic                   dma_a;
    logic                   ch_c;
    logic [2:0]             dx_err;
    logic [NUM_ACTIONS-1:0] act_pulse;
    logic [PGM_ADDR_W-1:0]  last_jump_addr;

    logic [31:0]            rnd_state;
    logic [PGM_W-1:0]       prog [PGM_DEPTH];         // copy of the loaded program
    logic [PGM_ADDR_W-1:0]  blk_addr [NUM_BLKS];      // block entry points
    string                  test_name;
    int                     test_idx = 0;
    int                     errors = 0;
    int                     checks = 0;
    int                     n_pulses;
    int                     n_async;
    int                     wdog_test = 0;
    int                     wdog_count = 0;

    ahci_fsm dut (.*);

    initial mclk = 1'b0;
    always #2 mclk = ~mclk;                           // 4 ns period

    function automatic logic [31:0] rand_u32();
        rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
        return rnd_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] r;
        r = rand_u32();
        return (r >> 8) % n;                          // low lcg bits are weak
    endfunction

    // condition table, evaluated on the inputs as last driven
    function automatic logic cond_true(input logic [COND_SEL_W-1:0] sel);
        logic nb_nd;
        nb_nd = !tfd_sts[7] && !tfd_sts[3];
        case (int'(sel))
            COND_ALWAYS:          return 1'b1;
            COND_FIS_OK:          return fis_ok;
            COND_FIS_ERR:         return fis_err;
            COND_FIS_FERR:        return fis_ferr;
            COND_FR_D2HR:         return fis_first_vld && (fis_type == 8'h34);
            COND_FIS_DATA:        return fis_first_vld && (fis_type == 8'h46);
            COND_FIS_ANY:         return fis_first_vld;
            COND_NB_ND:           return nb_nd;
            COND_TFD_ERR:         return tfd_sts[0];
            COND_ST_NB_ND:        return pcmd_st && nb_nd;
            COND_XFER0:           return xfer_cntr_zero && !dma_cmd_busy;
            COND_CHW_DMAA:        return ch_w && dma_a;
            COND_CTBA_C:          return ch_c;
            COND_TX_ERR:          return dx_err[1];
            COND_SYNCESC_ERR:     return dx_err[0];
            COND_X_RDY_COLLISION: return dx_err[2];
            default:              return 1'b0;    // undefined select
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error in %s: %s", test_name, what);
    endtask

    // writes one block at base through the address and data strobes
    task automatic gen_block(input logic [PGM_ADDR_W-1:0] base, input int n_act,
                             input int n_tr);
        logic [PGM_W-1:0]      w;
        logic [ACT_CODE_W-1:0] code;
        logic [COND_SEL_W-1:0] sel;
        int                    i;
        @(posedge mclk);
        pgm_ad <= PGM_W'(base);
        pgm_wa <= 1'b1;
        pgm_wd <= 1'b0;
        for (i = 0; i < n_act + n_tr; i++) begin
            w = '0;
            if (i < n_act) begin
                // first action always visible, waits only on visible actions
                code = (i == 0) ? ACT_CODE_W'(1 + rand_below(31)) : ACT_CODE_W'(rand_below(32));
                w[ACT_CODE_W-1:0] = code;
                w[WAIT_BIT]       = (code != '0) && (rand_below(3) == 0);
                w[LAST_BIT]       = (i == n_act - 1);
            end else begin
                sel = (i == n_act + n_tr - 1) ? COND_SEL_W'(COND_ALWAYS) :
                                                COND_SEL_W'(rand_below(20));
                w[COND_SEL_LSB +: COND_SEL_W] = sel;
                w[TARGET_LSB +: PGM_ADDR_W]   = blk_addr[rand_below(NUM_BLKS)];
            end
            prog[PGM_ADDR_W'(base + i)] = w;
            @(posedge mclk);
            pgm_ad <= w;
            pgm_wa <= 1'b0;
            pgm_wd <= 1'b1;                           // write, then advance
        end
        @(posedge mclk);
        pgm_wd <= 1'b0;
    endtask

    task automatic build_program();
        int i;
        blk_addr[0] = LABEL_POR;
        blk_addr[1] = LABEL_HBA_RST;
        blk_addr[2] = LABEL_PORT_RST;
        blk_addr[3] = LABEL_COMINIT;
        blk_addr[4] = LABEL_ST_CLEARED;
        for (i = 0; i < NUM_EXTRA; i++)
            blk_addr[5 + i] = PGM_ADDR_W'(16 + 16 * i + rand_below(8));  // 16-word slots
        for (i = 0; i < 4; i++)
            gen_block(blk_addr[i], 1, 1);             // labels two words apart
        for (i = 4; i < NUM_BLKS; i++)
            gen_block(blk_addr[i], 1 + rand_below(4), 1 + rand_below(3));
    endtask

    task automatic shuffle_conditions();
        logic [31:0] r;
        r = rand_u32();
        fis_ok        <= r[8];
        fis_err       <= r[9];
        fis_ferr      <= r[10];
        fis_first_vld <= r[11];
        fis_type      <= (r[13:12] == 2'd0) ? 8'h34 :
                         (r[13:12] == 2'd1) ? 8'h46 : r[23:16];
        tfd_sts       <= r[31:24];
        r = rand_u32();
        pcmd_st        <= r[8];
        xfer_cntr_zero <= r[9];
        dma_cmd_busy   <= r[10];
        ch_w           <= r[11];
        dma_a          <= r[12];
        ch_c           <= r[13];
        dx_err         <= r[16:14];
    endtask

    task automatic check_stall(input int unsigned cycles);
        int unsigned i;
        for (i = 0; i < cycles; i++) begin
            @(negedge mclk);
            checks++;
            if (act_pulse != '0)
                report_failure("act_pulse seen while the sequencer waits for done");
        end
    endtask

    task automatic expect_pulse(input logic [ACT_CODE_W-1:0] code,
                                input logic [PGM_ADDR_W-1:0] label);
        do begin
            @(negedge mclk);                          // outputs settled here
        end while (act_pulse == '0);
        checks += 3;
        n_pulses++;
        if (!$onehot(act_pulse))
            report_failure("act_pulse has more than one bit set");
        if (act_pulse !== (32'd1 << code))
            report_mismatch("act_pulse", 32'd1 << code, act_pulse);
        if (last_jump_addr !== label)
            report_mismatch("last_jump_addr", 32'(label), 32'(last_jump_addr));
    endtask

    // stall after a waiting action, ended by done or by an async jump
    task automatic serve_wait(output logic [PGM_ADDR_W-1:0] jump_to, output bit jumped);
        int unsigned kind;
        logic [1:0]  which;
        jumped  = 1'b0;
        jump_to = '0;
        @(posedge mclk);
        shuffle_conditions();                         // inputs move only here
        check_stall(1 + rand_below(4));
        kind = rand_below(8);
        if (kind <= 1) begin
            @(posedge mclk);
            cominit_got    <= 1'b1;
            unsolicited_en <= (kind == 0);            // ignored when disabled
            @(posedge mclk);
            cominit_got    <= 1'b0;
            unsolicited_en <= 1'b0;
            jumped  = (kind == 0);
            jump_to = LABEL_COMINIT;
        end else if (kind == 2) begin
            @(posedge mclk);
            pcmd_st_cleared <= 1'b1;
            @(posedge mclk);
            pcmd_st_cleared <= 1'b0;
            jumped  = 1'b1;
            jump_to = LABEL_ST_CLEARED;
        end
        if (!jumped) begin
            check_stall(1);
            which = 2'(rand_below(3));
            @(posedge mclk);
            fis_done   <= (which == 2'd0);
            xmit_done  <= (which == 2'd1);
            abort_done <= (which == 2'd2);
            @(posedge mclk);
            fis_done   <= 1'b0;
            xmit_done  <= 1'b0;
            abort_done <= 1'b0;
        end
    endtask

    task automatic run_test(input string name, input logic hba_flag, input logic port_flag);
        logic [PGM_ADDR_W-1:0] pc;
        logic [PGM_ADDR_W-1:0] label;
        logic [PGM_ADDR_W-1:0] jump_to;
        logic [PGM_W-1:0]      w;
        bit                    jumped;
        int                    blk;
        int                    err_start;
        test_name = name;
        test_idx++;                                   // restarts the watchdog
        err_start = errors;
        n_pulses  = 0;
        n_async   = 0;
        @(posedge mclk);
        hba_rst      <= 1'b1;
        was_hba_rst  <= hba_flag;
        was_port_rst <= port_flag;
        shuffle_conditions();
        build_program();
        repeat (16) begin
            @(negedge mclk);
            checks++;
            if (act_pulse != '0)
                report_failure("act_pulse active during reset");
        end
        @(posedge mclk);
        hba_rst <= 1'b0;
        label = hba_flag ? LABEL_HBA_RST : (port_flag ? LABEL_PORT_RST : LABEL_POR);
        for (blk = 0; blk < RUN_BLOCKS; blk++) begin
            pc     = label;
            jumped = 1'b0;
            do begin                                  // action phase
                w = prog[pc];
                pc++;
                if (w[ACT_CODE_W-1:0] != '0)
                    expect_pulse(w[ACT_CODE_W-1:0], label);
                if (w[WAIT_BIT])
                    serve_wait(jump_to, jumped);
            end while (!w[LAST_BIT] && !jumped);
            if (jumped) begin
                n_async++;
                label = jump_to;                      // rest of block abandoned
            end else begin
                // first true transition wins, list ends with an always word
                while (!cond_true(prog[pc][COND_SEL_LSB +: COND_SEL_W]))
                    pc++;
                label = prog[pc][TARGET_LSB +: PGM_ADDR_W];
            end
        end
        $display("test %s finished: %0d blocks, %0d pulses, %0d async jumps, %0d errors",
                 name, RUN_BLOCKS, n_pulses, n_async, errors - err_start);
    endtask

    // per test limit, counted from the start of each test
    always @(posedge mclk) begin
        if (test_idx != wdog_test) begin
            wdog_test  <= test_idx;
            wdog_count <= 0;
        end else begin
            wdog_count <= wdog_count + 1;
            if (wdog_count > WDOG_CYCLES) begin
                $display("Timeout in %s: expected act_pulse did not arrive within %0d cycles",
                         test_name, WDOG_CYCLES);
                $display("TB FAILED");
                $finish;
            end
        end
    end

    initial begin
        rnd_state       = 32'hdd54_c96b;
        hba_rst         = 1'b1;
        was_hba_rst     = 1'b0;
        was_port_rst    = 1'b0;
        pgm_ad          = '0;
        pgm_wa          = 1'b0;
        pgm_wd          = 1'b0;
        fis_done        = 1'b0;
        xmit_done       = 1'b0;
        abort_done      = 1'b0;
        cominit_got     = 1'b0;
        unsolicited_en  = 1'b0;
        pcmd_st_cleared = 1'b0;
        fis_ok          = 1'b0;
        fis_err         = 1'b0;
        fis_ferr        = 1'b0;
        fis_first_vld   = 1'b0;
        fis_type        = '0;
        tfd_sts         = '0;
        pcmd_st         = 1'b0;
        xfer_cntr_zero  = 1'b0;
        dma_cmd_busy    = 1'b0;
        ch_w            = 1'b0;
        dma_a           = 1'b0;
        ch_c            = 1'b0;
        dx_err          = '0;
        run_test("entry_por", 1'b0, 1'b0);
        run_test("entry_hba_rst", 1'b1, 1'b0);
        run_test("entry_port_rst", 1'b0, 1'b1);
        run_test("entry_hba_and_port", 1'b1, 1'b1);  // hba reset takes priority
        $display("tests %0d, checks %0d, errors %0d", test_idx, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
ahci_seq_pkg.sv
verilog/fsm_program_ram.sv
verilog/fsm_sequencer.sv
verilog/action_decoder.sv
verilog/condition_mux.sv
verilog/ahci_fsm.sv
sim/tb_ahci_fsm.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, then decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_ahci_fsm -o tb_ahci_fsm \
    && ./obj_dir/tb_ahci_fsm | tee sim.log \
    || { echo "build or run error"; exit 1; }
grep -q "^TB PASSED$" sim.log \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }
